/* list.f */
hdl/smartnic_pkg.sv
hdl/axi4s_intf.sv
hdl/p2p_regs.sv
hdl/p2p_lane.sv
hdl/host_term.sv
hdl/smartnic_app.sv
testbench/tb_smartnic_app.sv

/* run.sh */
#!/bin/sh
verilator --binary -f list.f --top-module tb_smartnic_app \
    && ./obj_dir/Vtb_smartnic_app \
    || exit 1

/* testbench/tb_smartnic_app.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_smartnic_app import smartnic_pkg::*; ();

    localparam int PKTS_PER_PHASE = 12;
    localparam int NUM_PHASES     = 4;
    localparam int TOTAL_PKTS     = PKTS_PER_PHASE * NUM_PHASES * NUM_PORTS;
    localparam int MAX_BEATS      = 6;
    localparam int WATCHDOG_CYC   = 200 * TOTAL_PKTS + 1000;

    typedef logic [127:0] word_t;

    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
        port_t id;
        port_t dest;
        pid_t  pid;
    } beat_t;

    logic      core_clk = 1'b0;
    logic      rst;
    logic      reg_wr, reg_rd, reg_rd_valid;
    reg_addr_t reg_addr;
    reg_data_t reg_wdata, reg_rdata;

    logic [NUM_PORTS-1:0]        axis_app_igr_tvalid, axis_app_igr_tready, axis_app_igr_tlast;
    logic [NUM_PORTS*DATA_W-1:0] axis_app_igr_tdata;
    logic [NUM_PORTS*KEEP_W-1:0] axis_app_igr_tkeep;
    logic [NUM_PORTS*PORT_W-1:0] axis_app_igr_tid, axis_app_igr_tdest;
    logic [NUM_PORTS*PID_W-1:0]  axis_app_igr_tuser_pid;
    logic [NUM_PORTS-1:0]        axis_app_egr_tvalid, axis_app_egr_tready, axis_app_egr_tlast;
    logic [NUM_PORTS*DATA_W-1:0] axis_app_egr_tdata;
    logic [NUM_PORTS*KEEP_W-1:0] axis_app_egr_tkeep;
    logic [NUM_PORTS*PORT_W-1:0] axis_app_egr_tid, axis_app_egr_tdest;
    logic [NUM_PORTS*PID_W-1:0]  axis_app_egr_tuser_pid;
    logic [NUM_PORTS-1:0]        axis_h2c_tvalid, axis_h2c_tready, axis_h2c_tlast;
    logic [NUM_PORTS*DATA_W-1:0] axis_h2c_tdata;
    logic [NUM_PORTS*KEEP_W-1:0] axis_h2c_tkeep;
    logic [NUM_PORTS*PORT_W-1:0] axis_h2c_tid, axis_h2c_tdest;
    logic [NUM_PORTS*PID_W-1:0]  axis_h2c_tuser_pid;
    logic [NUM_PORTS-1:0]        axis_c2h_tvalid, axis_c2h_tready, axis_c2h_tlast;
    logic [NUM_PORTS*DATA_W-1:0] axis_c2h_tdata;
    logic [NUM_PORTS*KEEP_W-1:0] axis_c2h_tkeep;
    logic [NUM_PORTS*PORT_W-1:0] axis_c2h_tid, axis_c2h_tdest;
    logic [NUM_PORTS*PID_W-1:0]  axis_c2h_tuser_pid;

    // Beats still to send per ingress port, expected and received per egress port
    beat_t send_q [NUM_PORTS][$];
    beat_t exp_q  [NUM_PORTS][$];
    beat_t rx_q   [NUM_PORTS][$];

    // Packet model
    logic [NUM_PORTS-1:0] ctrl_en = 2'b11;
    int                   fwd_model  [NUM_PORTS] = '{0, 0};
    int                   drop_model [NUM_PORTS] = '{0, 0};
    int                   h2c_sent = 0;
    logic                 stress = 1'b0;
    logic                 h2c_on = 1'b0;

    smartnic_app dut (.*);

    always #4 core_clk = ~core_clk;

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    // Only tdest changes and becomes the peer port
    function automatic beat_t egress_beat(input beat_t b, input int in_port);
        beat_t e;
        e      = b;
        e.dest = port_t'(1 - in_port);
        return e;
    endfunction

    function automatic reg_data_t model_reg(input reg_addr_t addr);
        case (addr)
            REG_CTRL:  return reg_data_t'(ctrl_en);
            REG_FWD0:  return reg_data_t'(fwd_model[0]);
            REG_DROP0: return reg_data_t'(drop_model[0]);
            REG_FWD1:  return reg_data_t'(fwd_model[1]);
            REG_DROP1: return reg_data_t'(drop_model[1]);
            REG_H2C:   return reg_data_t'(h2c_sent);
            default:   return '0;
        endcase
    endfunction

    task automatic fail_now();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            fail_now();
        end
    endtask

    // Fate follows the enable in force when the packet is queued
    task automatic queue_packet(input int p);
        int    len;
        beat_t b;
        len   = $urandom_range(MAX_BEATS, 1);
        b.id  = port_t'($urandom);
        b.pid = pid_t'($urandom);
        for (int i = 0; i < len; i++) begin
            b.data = {$urandom, $urandom};
            b.last = (i == len - 1);
            b.keep = b.last ? (keep_t'($urandom) | keep_t'(1)) : '1;
            b.dest = port_t'($urandom);
            send_q[p].push_back(b);
            if (ctrl_en[p]) begin
                exp_q[1 - p].push_back(egress_beat(b, p));
            end
        end
        if (ctrl_en[p]) begin
            fwd_model[p]++;
        end else begin
            drop_model[p]++;
        end
    endtask

    // ------------------------------------------------------------
    // Register port
    // ------------------------------------------------------------
    task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge core_clk);
        reg_wr <= 1'b0;
        @(posedge core_clk);
    endtask

    task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
        reg_rd   <= 1'b1;
        reg_addr <= addr;
        @(posedge core_clk);
        reg_rd <= 1'b0;
        check(word_t'(reg_rd_valid), word_t'(0), "reg_rd_valid in the strobe cycle");
        @(posedge core_clk);
        check(word_t'(reg_rd_valid), word_t'(1), "reg_rd_valid one cycle after reg_rd");
        data = reg_rdata;
    endtask

    // Whole map plus one unmapped word
    task automatic check_regs();
        reg_data_t rd;
        for (int a = 0; a <= 'h18; a += 4) begin
            reg_read(reg_addr_t'(a), rd);
            check(word_t'(rd), word_t'(model_reg(reg_addr_t'(a))),
                  $sformatf("register 0x%02h", a));
        end
    endtask

    function automatic bit busy();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (send_q[p].size() != 0 || exp_q[p].size() != 0) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic run_phase(input logic [NUM_PORTS-1:0] en, input logic stress_on);
        ctrl_en = en;
        reg_write(REG_CTRL, reg_data_t'(en));
        stress = stress_on;
        for (int n = 0; n < PKTS_PER_PHASE; n++) begin
            queue_packet(0);
            queue_packet(1);
        end
        while (busy()) begin
            @(posedge core_clk);
        end
        repeat (4) @(posedge core_clk);
    endtask

    // ------------------------------------------------------------
    // Stream drivers and monitors
    // ------------------------------------------------------------
    initial begin : igr_driver
        axis_app_igr_tvalid    <= '0;
        axis_app_igr_tdata     <= '0;
        axis_app_igr_tkeep     <= '0;
        axis_app_igr_tlast     <= '0;
        axis_app_igr_tid       <= '0;
        axis_app_igr_tdest     <= '0;
        axis_app_igr_tuser_pid <= '0;
        forever begin
            @(posedge core_clk);
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (axis_app_igr_tvalid[p] && axis_app_igr_tready[p]) begin
                    void'(send_q[p].pop_front());
                end
                // Fields only move when the current beat is gone
                if (!axis_app_igr_tvalid[p] || axis_app_igr_tready[p]) begin
                    if (send_q[p].size() > 0 && (!stress || $urandom_range(3) != 0)) begin
                        axis_app_igr_tvalid[p]                    <= 1'b1;
                        axis_app_igr_tdata[p*DATA_W +: DATA_W]    <= send_q[p][0].data;
                        axis_app_igr_tkeep[p*KEEP_W +: KEEP_W]    <= send_q[p][0].keep;
                        axis_app_igr_tlast[p]                     <= send_q[p][0].last;
                        axis_app_igr_tid[p*PORT_W +: PORT_W]      <= send_q[p][0].id;
                        axis_app_igr_tdest[p*PORT_W +: PORT_W]    <= send_q[p][0].dest;
                        axis_app_igr_tuser_pid[p*PID_W +: PID_W]  <= send_q[p][0].pid;
                    end else begin
                        axis_app_igr_tvalid[p] <= 1'b0;
                    end
                end
            end
        end
    end

    initial begin : h2c_and_backpressure
        axis_app_egr_tready <= '1;
        axis_h2c_tvalid     <= '0;
        axis_h2c_tdata      <= '0;
        axis_h2c_tkeep      <= '0;
        axis_h2c_tlast      <= '0;
        axis_h2c_tid        <= '0;
        axis_h2c_tdest      <= '0;
        axis_h2c_tuser_pid  <= '0;
        axis_c2h_tready     <= '1;
        forever begin
            @(posedge core_clk);
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (axis_h2c_tvalid[p]) begin
                    check(word_t'(axis_h2c_tready[p]), word_t'(1), "h2c tready");
                    h2c_sent++;
                end
                axis_h2c_tvalid[p]                 <= h2c_on && $urandom_range(1) == 1;
                axis_h2c_tdata[p*DATA_W +: DATA_W] <= {$urandom, $urandom};
                axis_app_egr_tready[p]             <= !stress || $urandom_range(2) != 0;
            end
        end
    end

    initial begin : egr_monitor
        beat_t b;
        forever begin
            @(posedge core_clk);
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (axis_app_egr_tvalid[p] && axis_app_egr_tready[p]) begin
                    b.data = axis_app_egr_tdata[p*DATA_W +: DATA_W];
                    b.keep = axis_app_egr_tkeep[p*KEEP_W +: KEEP_W];
                    b.last = axis_app_egr_tlast[p];
                    b.id   = axis_app_egr_tid[p*PORT_W +: PORT_W];
                    b.dest = axis_app_egr_tdest[p*PORT_W +: PORT_W];
                    b.pid  = axis_app_egr_tuser_pid[p*PID_W +: PID_W];
                    rx_q[p].push_back(b);
                end
            end
            check(word_t'(axis_c2h_tvalid), word_t'(0), "c2h tvalid");
            check(word_t'(axis_c2h_tdata), word_t'(0), "c2h tdata");
            check(word_t'({axis_c2h_tkeep, axis_c2h_tlast, axis_c2h_tid,
                           axis_c2h_tdest, axis_c2h_tuser_pid}),
                  word_t'(0), "c2h sideband fields");
        end
    end

    initial begin : compare
        forever begin
            @(posedge core_clk);
            for (int p = 0; p < NUM_PORTS; p++) begin
                while (rx_q[p].size() > 0) begin
                    if (exp_q[p].size() == 0) begin
                        $display("Egress port %0d sent a beat that was not expected at %0t ns",
                                 p, $time);
                        fail_now();
                    end else begin
                        check(word_t'(rx_q[p].pop_front()), word_t'(exp_q[p].pop_front()),
                              $sformatf("egress port %0d beat", p));
                    end
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYC) @(posedge core_clk);
        $display("Timeout: traffic did not finish within %0d cycles", WATCHDOG_CYC);
        fail_now();
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin : main
        void'($urandom(32'hf5e3ca00));
        rst       <= 1'b1;
        reg_wr    <= 1'b0;
        reg_rd    <= 1'b0;
        reg_addr  <= '0;
        reg_wdata <= '0;
        repeat (4) @(posedge core_clk);
        rst <= 1'b0;
        @(posedge core_clk);
        check(word_t'(axis_app_egr_tvalid), word_t'(0), "egr tvalid after reset");
        check(word_t'(axis_app_igr_tready), word_t'(2'b11), "igr tready after reset");
        check_regs();

        h2c_on = 1'b1;
        // Plain forwarding, then random gaps and back-pressure
        run_phase(2'b11, 1'b0);
        run_phase(2'b11, 1'b1);
        // Lane 0 off drops its packets, then back on
        run_phase(2'b10, 1'b1);
        run_phase(2'b11, 1'b1);

        h2c_on = 1'b0;
        repeat (4) @(posedge core_clk);
        check_regs();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/smartnic_app.sv */
`timescale 1ns/1ps
`default_nettype none

module smartnic_app import smartnic_pkg::*; (
    input  logic                          core_clk,
    input  logic                          rst,

    // Register port
    input  logic                          reg_wr,
    input  logic                          reg_rd,
    input  reg_addr_t                     reg_addr,
    input  reg_data_t                     reg_wdata,
    output reg_data_t                     reg_rdata,
    output logic                          reg_rd_valid,

    // Ingress from switch
    input  logic [NUM_PORTS-1:0]          axis_app_igr_tvalid,
    output logic [NUM_PORTS-1:0]          axis_app_igr_tready,
    input  logic [NUM_PORTS*DATA_W-1:0]   axis_app_igr_tdata,
    input  logic [NUM_PORTS*KEEP_W-1:0]   axis_app_igr_tkeep,
    input  logic [NUM_PORTS-1:0]          axis_app_igr_tlast,
    input  logic [NUM_PORTS*PORT_W-1:0]   axis_app_igr_tid,
    input  logic [NUM_PORTS*PORT_W-1:0]   axis_app_igr_tdest,
    input  logic [NUM_PORTS*PID_W-1:0]    axis_app_igr_tuser_pid,

    // Egress to switch
    output logic [NUM_PORTS-1:0]          axis_app_egr_tvalid,
    input  logic [NUM_PORTS-1:0]          axis_app_egr_tready,
    output logic [NUM_PORTS*DATA_W-1:0]   axis_app_egr_tdata,
    output logic [NUM_PORTS*KEEP_W-1:0]   axis_app_egr_tkeep,
    output logic [NUM_PORTS-1:0]          axis_app_egr_tlast,
    output logic [NUM_PORTS*PORT_W-1:0]   axis_app_egr_tid,
    output logic [NUM_PORTS*PORT_W-1:0]   axis_app_egr_tdest,
    output logic [NUM_PORTS*PID_W-1:0]    axis_app_egr_tuser_pid,

    // Host to card
    input  logic [NUM_PORTS-1:0]          axis_h2c_tvalid,
    output logic [NUM_PORTS-1:0]          axis_h2c_tready,
    input  logic [NUM_PORTS*DATA_W-1:0]   axis_h2c_tdata,
    input  logic [NUM_PORTS*KEEP_W-1:0]   axis_h2c_tkeep,
    input  logic [NUM_PORTS-1:0]          axis_h2c_tlast,
    input  logic [NUM_PORTS*PORT_W-1:0]   axis_h2c_tid,
    input  logic [NUM_PORTS*PORT_W-1:0]   axis_h2c_tdest,
    input  logic [NUM_PORTS*PID_W-1:0]    axis_h2c_tuser_pid,

    // Card to host
    output logic [NUM_PORTS-1:0]          axis_c2h_tvalid,
    input  logic [NUM_PORTS-1:0]          axis_c2h_tready,
    output logic [NUM_PORTS*DATA_W-1:0]   axis_c2h_tdata,
    output logic [NUM_PORTS*KEEP_W-1:0]   axis_c2h_tkeep,
    output logic [NUM_PORTS-1:0]          axis_c2h_tlast,
    output logic [NUM_PORTS*PORT_W-1:0]   axis_c2h_tid,
    output logic [NUM_PORTS*PORT_W-1:0]   axis_c2h_tdest,
    output logic [NUM_PORTS*PID_W-1:0]    axis_c2h_tuser_pid
);

    axi4s_intf axis_igr [NUM_PORTS] ();
    axi4s_intf axis_egr [NUM_PORTS] ();
    axi4s_intf axis_h2c [NUM_PORTS] ();
    axi4s_intf axis_c2h [NUM_PORTS] ();

    logic [NUM_PORTS-1:0] lane_en;
    logic [NUM_PORTS-1:0] fwd_pkt;
    logic [NUM_PORTS-1:0] drop_pkt;
    logic [NUM_PORTS-1:0] h2c_beat;

    // ------------------------------------------------------------
    // Flat vectors to interfaces
    // ------------------------------------------------------------
    for (genvar j = 0; j < NUM_PORTS; j++) begin : g_port
        assign axis_igr[j].tvalid     = axis_app_igr_tvalid[j];
        assign axis_app_igr_tready[j] = axis_igr[j].tready;
        assign axis_igr[j].tdata      = axis_app_igr_tdata[j*DATA_W +: DATA_W];
        assign axis_igr[j].tkeep      = axis_app_igr_tkeep[j*KEEP_W +: KEEP_W];
        assign axis_igr[j].tlast      = axis_app_igr_tlast[j];
        assign axis_igr[j].tid        = axis_app_igr_tid[j*PORT_W +: PORT_W];
        assign axis_igr[j].tdest      = axis_app_igr_tdest[j*PORT_W +: PORT_W];
        assign axis_igr[j].tuser      = axis_app_igr_tuser_pid[j*PID_W +: PID_W];

        assign axis_app_egr_tvalid[j]                   = axis_egr[j].tvalid;
        assign axis_egr[j].tready                       = axis_app_egr_tready[j];
        assign axis_app_egr_tdata[j*DATA_W +: DATA_W]   = axis_egr[j].tdata;
        assign axis_app_egr_tkeep[j*KEEP_W +: KEEP_W]   = axis_egr[j].tkeep;
        assign axis_app_egr_tlast[j]                    = axis_egr[j].tlast;
        assign axis_app_egr_tid[j*PORT_W +: PORT_W]     = axis_egr[j].tid;
        assign axis_app_egr_tdest[j*PORT_W +: PORT_W]   = axis_egr[j].tdest;
        assign axis_app_egr_tuser_pid[j*PID_W +: PID_W] = axis_egr[j].tuser;

        assign axis_h2c[j].tvalid = axis_h2c_tvalid[j];
        assign axis_h2c_tready[j] = axis_h2c[j].tready;
        assign axis_h2c[j].tdata  = axis_h2c_tdata[j*DATA_W +: DATA_W];
        assign axis_h2c[j].tkeep  = axis_h2c_tkeep[j*KEEP_W +: KEEP_W];
        assign axis_h2c[j].tlast  = axis_h2c_tlast[j];
        assign axis_h2c[j].tid    = axis_h2c_tid[j*PORT_W +: PORT_W];
        assign axis_h2c[j].tdest  = axis_h2c_tdest[j*PORT_W +: PORT_W];
        assign axis_h2c[j].tuser  = axis_h2c_tuser_pid[j*PID_W +: PID_W];

        assign axis_c2h_tvalid[j]                   = axis_c2h[j].tvalid;
        assign axis_c2h[j].tready                   = axis_c2h_tready[j];
        assign axis_c2h_tdata[j*DATA_W +: DATA_W]   = axis_c2h[j].tdata;
        assign axis_c2h_tkeep[j*KEEP_W +: KEEP_W]   = axis_c2h[j].tkeep;
        assign axis_c2h_tlast[j]                    = axis_c2h[j].tlast;
        assign axis_c2h_tid[j*PORT_W +: PORT_W]     = axis_c2h[j].tid;
        assign axis_c2h_tdest[j*PORT_W +: PORT_W]   = axis_c2h[j].tdest;
        assign axis_c2h_tuser_pid[j*PID_W +: PID_W] = axis_c2h[j].tuser;

        host_term u_host_term (
            .core_clk ( core_clk ),
            .rst      ( rst ),
            .h2c      ( axis_h2c[j] ),
            .c2h      ( axis_c2h[j] ),
            .h2c_beat ( h2c_beat[j] )
        );
    end

    // ------------------------------------------------------------
    // Peer to peer lanes, port 0 <-> port 1
    // ------------------------------------------------------------
    p2p_lane #(.OUT_PORT(port_t'(1))) u_lane_0 (
        .core_clk ( core_clk ),
        .rst      ( rst ),
        .lane_en  ( lane_en[0] ),
        .in       ( axis_igr[0] ),
        .out      ( axis_egr[1] ),
        .fwd_pkt  ( fwd_pkt[0] ),
        .drop_pkt ( drop_pkt[0] )
    );

    p2p_lane #(.OUT_PORT(port_t'(0))) u_lane_1 (
        .core_clk ( core_clk ),
        .rst      ( rst ),
        .lane_en  ( lane_en[1] ),
        .in       ( axis_igr[1] ),
        .out      ( axis_egr[0] ),
        .fwd_pkt  ( fwd_pkt[1] ),
        .drop_pkt ( drop_pkt[1] )
    );

    p2p_regs u_regs (
        .core_clk     ( core_clk ),
        .rst          ( rst ),
        .reg_wr       ( reg_wr ),
        .reg_rd       ( reg_rd ),
        .reg_addr     ( reg_addr ),
        .reg_wdata    ( reg_wdata ),
        .reg_rdata    ( reg_rdata ),
        .reg_rd_valid ( reg_rd_valid ),
        .lane_en      ( lane_en ),
        .fwd_pkt      ( fwd_pkt ),
        .drop_pkt     ( drop_pkt ),
        .h2c_beat     ( h2c_beat )
    );

endmodule

`default_nettype wire

/* hdl/host_term.sv */
`timescale 1ns/1ps
`default_nettype none

module host_term import smartnic_pkg::*; (
    input  logic  core_clk,
    input  logic  rst,

    axi4s_intf.rx h2c,
    axi4s_intf.tx c2h,

    output logic  h2c_beat
);

    logic h2c_ready_q;

    // ------------------------------------------------------------
    // h2c sink
    // ------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (rst) begin
            h2c_ready_q <= 1'b0;
        end else begin
            h2c_ready_q <= 1'b1;
        end
    end

    assign h2c.tready = h2c_ready_q;
    assign h2c_beat   = h2c.tvalid && h2c_ready_q;

    // c2h stays idle
    assign c2h.tvalid = 1'b0;
    assign c2h.tdata  = '0;
    assign c2h.tkeep  = '0;
    assign c2h.tlast  = 1'b0;
    assign c2h.tid    = '0;
    assign c2h.tdest  = '0;
    assign c2h.tuser  = pid_t'(0);

endmodule

`default_nettype wire

/* hdl/p2p_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module p2p_lane import smartnic_pkg::*; #(
    parameter port_t OUT_PORT = port_t'(0)
) (
    input  logic core_clk,
    input  logic rst,
    input  logic lane_en,

    axi4s_intf.rx in,
    axi4s_intf.tx out,

    output logic fwd_pkt,
    output logic drop_pkt
);

    lane_state_t state;

    logic  drop_now;
    logic  in_fire;
    logic  out_fire;

    // Output stage
    logic  valid_q;
    data_t data_q;
    keep_t keep_q;
    logic  last_q;
    port_t id_q;
    pid_t  pid_q;

    // ------------------------------------------------------------
    // Packet fate
    // ------------------------------------------------------------
    // First beat takes the live enable, later beats follow the state
    assign drop_now = (state == DROP) || (state == IDLE && !lane_en);

    // Dropped beats never wait on the output
    assign in.tready = drop_now || !valid_q || out.tready;
    assign in_fire   = in.tvalid && in.tready;
    assign out_fire  = valid_q && out.tready;

    always_ff @(posedge core_clk) begin
        if (rst) begin
            state <= IDLE;
        end else if (in_fire) begin
            if (in.tlast) begin
                state <= IDLE;
            end else if (state == IDLE) begin
                state <= lane_en ? PASS : DROP;
            end
        end
    end

    // ------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (in_fire && !drop_now) begin
            valid_q <= 1'b1;
        end else if (out_fire) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge core_clk) begin
        if (in_fire && !drop_now) begin
            data_q <= in.tdata;
            keep_q <= in.tkeep;
            last_q <= in.tlast;
            id_q   <= in.tid;
            pid_q  <= in.tuser;
        end
    end

    assign out.tvalid = valid_q;
    assign out.tdata  = data_q;
    assign out.tkeep  = keep_q;
    assign out.tlast  = last_q;
    assign out.tid    = id_q;
    assign out.tuser  = pid_q;
    // Destination is always the peer switch port
    assign out.tdest  = OUT_PORT;

    // End of packet events
    assign fwd_pkt  = out_fire && last_q;
    assign drop_pkt = in_fire && drop_now && in.tlast;

endmodule

`default_nettype wire

/* hdl/p2p_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module p2p_regs import smartnic_pkg::*; (
    input  logic                 core_clk,
    input  logic                 rst,

    input  logic                 reg_wr,
    input  logic                 reg_rd,
    input  reg_addr_t            reg_addr,
    input  reg_data_t            reg_wdata,
    output reg_data_t            reg_rdata,
    output logic                 reg_rd_valid,

    output logic [NUM_PORTS-1:0] lane_en,
    input  logic [NUM_PORTS-1:0] fwd_pkt,
    input  logic [NUM_PORTS-1:0] drop_pkt,
    input  logic [NUM_PORTS-1:0] h2c_beat
);

    logic [NUM_PORTS-1:0] lane_en_q;
    count_t               fwd_cnt  [NUM_PORTS];
    count_t               drop_cnt [NUM_PORTS];
    count_t               h2c_cnt;
    count_t               h2c_inc;

    assign lane_en = lane_en_q;

    // ------------------------------------------------------------
    // Control register
    // ------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (rst) begin
            lane_en_q <= CTRL_RESET;
        end else if (reg_wr && reg_addr == REG_CTRL) begin
            lane_en_q <= reg_wdata[NUM_PORTS-1:0];
        end
    end

    // ------------------------------------------------------------
    // Event counters
    // ------------------------------------------------------------
    // Several host ports may hand over a beat in the same cycle
    always_comb begin
        h2c_inc = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            h2c_inc = h2c_inc + count_t'(h2c_beat[i]);
        end
    end

    always_ff @(posedge core_clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                fwd_cnt[i]  <= '0;
                drop_cnt[i] <= '0;
            end
            h2c_cnt <= '0;
        end else begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                fwd_cnt[i]  <= fwd_cnt[i] + count_t'(fwd_pkt[i]);
                drop_cnt[i] <= drop_cnt[i] + count_t'(drop_pkt[i]);
            end
            h2c_cnt <= h2c_cnt + h2c_inc;
        end
    end

    // ------------------------------------------------------------
    // Readback, one cycle after the strobe
    // ------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (rst) begin
            reg_rd_valid <= 1'b0;
        end else begin
            reg_rd_valid <= reg_rd;
        end
    end

    always_ff @(posedge core_clk) begin
        if (reg_rd) begin
            case (reg_addr)
                REG_CTRL:  reg_rdata <= reg_data_t'(lane_en_q);
                REG_FWD0:  reg_rdata <= reg_data_t'(fwd_cnt[0]);
                REG_DROP0: reg_rdata <= reg_data_t'(drop_cnt[0]);
                REG_FWD1:  reg_rdata <= reg_data_t'(fwd_cnt[1]);
                REG_DROP1: reg_rdata <= reg_data_t'(drop_cnt[1]);
                REG_H2C:   reg_rdata <= reg_data_t'(h2c_cnt);
                default:   reg_rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/axi4s_intf.sv */
`timescale 1ns/1ps
`default_nettype none

interface axi4s_intf import smartnic_pkg::*; ();

    logic  tvalid;
    logic  tready;
    data_t tdata;
    keep_t tkeep;
    logic  tlast;
    port_t tid;
    port_t tdest;
    pid_t  tuser;

    modport tx (
        output tvalid, tdata, tkeep, tlast, tid, tdest, tuser,
        input  tready
    );

    modport rx (
        input  tvalid, tdata, tkeep, tlast, tid, tdest, tuser,
        output tready
    );

endinterface

`default_nettype wire

/* hdl/smartnic_pkg.sv */
`default_nettype none

package smartnic_pkg;

    // Port and stream geometry
    localparam int NUM_PORTS = 2;
    localparam int DATA_W    = 64;
    localparam int KEEP_W    = DATA_W / 8;
    localparam int PORT_W    = 2;
    localparam int PID_W     = 16;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [KEEP_W-1:0] keep_t;
    typedef logic [PORT_W-1:0] port_t;
    typedef logic [PID_W-1:0]  pid_t;

    typedef logic [31:0] count_t;
    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // ------------------------------------------------------------
    // Register map, byte addresses
    // ------------------------------------------------------------
    localparam reg_addr_t REG_CTRL  = 8'h00;
    localparam reg_addr_t REG_FWD0  = 8'h04;
    localparam reg_addr_t REG_DROP0 = 8'h08;
    localparam reg_addr_t REG_FWD1  = 8'h0C;
    localparam reg_addr_t REG_DROP1 = 8'h10;
    localparam reg_addr_t REG_H2C   = 8'h14;

    // Both lanes come up enabled
    localparam logic [NUM_PORTS-1:0] CTRL_RESET = '1;

    typedef enum logic [1:0] {IDLE, PASS, DROP} lane_state_t;

endpackage

`default_nettype wire
